// ==== md_bus_pkg.sv ====
// Shared bus types and map constants; ROM must sit below A00000 and work RAM mirrors over E00000-FFFFFF
package md_bus_pkg;

	// ----------------------------------------
	// Bus types
	// ----------------------------------------

	// Word address as driven by the 68000, byte lane picked by the strobes
	typedef logic [23:1] cpu_addr_t;

	typedef logic [15:0] word_t;

	// Sound-bus data is byte wide
	typedef logic [7:0]  byte_t;

	// ----------------------------------------
	// Main-bus memory map
	// ----------------------------------------

	// Upper address byte of the sound-CPU window A00000-A0FFFF
	localparam logic [7:0]  ZBUS_TOP = 8'hA0;

	// Work RAM E00000-FFFFFF
	localparam logic [2:0]  WRAM_TOP = 3'b111;

	// Sound-CPU control registers, byte addresses
	localparam logic [23:0] CTRL_BUSREQ_ADDR = 24'hA11100;
	localparam logic [23:0] CTRL_RESET_ADDR  = 24'hA11200;

	// ----------------------------------------
	// Reset and fill values
	// ----------------------------------------

	// NOP opcode, what the bus floats to before any real read
	localparam logic [15:0] OPEN_BUS_INIT = 16'h4E71;

	// Sound bus not granted or no RAM behind the address
	localparam logic [7:0]  ZBUS_FILL = 8'hFF;

	// Sound-bus address bit 14 set selects the FM range 4000-7FFF
	localparam int ZRAM_WINDOW_BIT = 14;

endpackage

// ==== work_ram.sv ====
// No reset and no clear, contents start undefined; smaller WRAM_AW mirrors within E00000-FFFFFF
`timescale 1ns/10ps

module work_ram #(
	parameter int WRAM_AW = 15
) (
	input  logic              MCLK,
	input  logic [14:0]       wram_addr,
	input  md_bus_pkg::word_t wram_wdata,
	input  logic              wram_we_hi,
	input  logic              wram_we_lo,
	output md_bus_pkg::word_t wram_rdata
);

	logic [WRAM_AW-1:0] idx;
	logic [1:0]         lane_we;

	// Upper address bits fall away when the RAM is built smaller
	assign idx     = wram_addr[WRAM_AW-1:0];
	assign lane_we = {wram_we_hi, wram_we_lo};

	// ----------------------------------------
	// One byte array per lane
	// ----------------------------------------

	for (genvar g = 0; g < 2; g++) begin : g_lane
		md_bus_pkg::byte_t mem [2**WRAM_AW];

		always_ff @(posedge MCLK) begin
			if (lane_we[g])
				mem[idx] <= wram_wdata[g*8 +: 8];
			// Read-before-write with data one cycle after the address
			wram_rdata[g*8 +: 8] <= mem[idx];
		end
	end

endmodule

// ==== zbus_ctrl.sv ====
// Main-bus side of the sound bus only; FM range 4000-7FFF has no chip behind it and reads FF
`timescale 1ns/10ps

module zbus_ctrl #(
	parameter int ZRAM_AW = 13
) (
	input  logic              MCLK,
	input  logic              reset,
	input  logic              zb_sel,
	input  logic [14:0]       zb_addr,
	input  md_bus_pkg::byte_t zb_wdata,
	input  logic              zb_rnw,
	input  logic              zb_busreq_n,
	input  logic              zb_reset_n,
	output md_bus_pkg::byte_t zb_rdata,
	output logic              zb_done
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_READ   = 2'd1;
	localparam logic [1:0] ST_FINISH = 2'd2;

	logic [1:0]        state;
	logic              granted;

	logic [14:0]       addr_q;
	md_bus_pkg::byte_t wdata_q;
	logic              we_q;
	logic              fill_q;

	md_bus_pkg::byte_t ram [2**ZRAM_AW];
	md_bus_pkg::byte_t ram_q;
	logic              ram_we;

	// Sound CPU has released the bus and is out of reset
	assign granted = !zb_busreq_n && zb_reset_n;

	// ----------------------------------------
	// Sound-bus state machine
	// ----------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state   <= ST_IDLE;
			zb_done <= 1'b0;
			we_q    <= 1'b0;
		end else begin
			zb_done <= 1'b0;

			case (state)
			ST_IDLE: begin
				// Select still high in the cycle done is seen is no new access
				if (zb_sel && !zb_done) begin
					addr_q  <= zb_addr;
					wdata_q <= zb_wdata;
					we_q    <= !zb_rnw && granted && !zb_addr[md_bus_pkg::ZRAM_WINDOW_BIT];
					fill_q  <= !granted || zb_addr[md_bus_pkg::ZRAM_WINDOW_BIT];
					state   <= ST_READ;
				end
			end

			ST_READ: begin
				we_q  <= 1'b0;
				state <= ST_FINISH;
			end

			ST_FINISH: begin
				zb_rdata <= fill_q ? md_bus_pkg::ZBUS_FILL : ram_q;
				zb_done  <= 1'b1;
				state    <= ST_IDLE;
			end

			default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// 8 KB sound RAM
	// ----------------------------------------

	assign ram_we = (state == ST_READ) && we_q;

	// Mirrors over 0000-3FFF with the default size
	always_ff @(posedge MCLK) begin
		if (ram_we)
			ram[addr_q[ZRAM_AW-1:0]] <= wdata_q;
		ram_q <= ram[addr_q[ZRAM_AW-1:0]];
	end

	// Done only ever answers a select the main bus is still holding
	a_done_in_sel: assert property (@(posedge MCLK) disable iff (reset)
		zb_done |-> zb_sel);

endmodule

// ==== mbus_ctrl.sv ====
// Master must hold address, strobes and data while AS is low; ROM writes are dropped, no bus arbitration
`timescale 1ns/10ps

module mbus_ctrl (
	input  logic                  MCLK,
	input  logic                  reset,
	input  logic                  cpu_as_n,
	input  logic                  cpu_rnw,
	input  logic                  cpu_uds_n,
	input  logic                  cpu_lds_n,
	input  md_bus_pkg::cpu_addr_t cpu_addr,
	input  md_bus_pkg::word_t     cpu_wdata,
	input  md_bus_pkg::word_t     rom_rdata,
	input  logic                  rom_ack,
	input  md_bus_pkg::cpu_addr_t rom_size,
	input  md_bus_pkg::word_t     wram_rdata,
	input  md_bus_pkg::byte_t     zb_rdata,
	input  logic                  zb_done,
	output md_bus_pkg::word_t     cpu_rdata,
	output logic                  cpu_dtack_n,
	output md_bus_pkg::cpu_addr_t rom_addr,
	output logic                  rom_req,
	output logic [14:0]           wram_addr,
	output md_bus_pkg::word_t     wram_wdata,
	output logic                  wram_we_hi,
	output logic                  wram_we_lo,
	output logic                  zb_sel,
	output logic [14:0]           zb_addr,
	output md_bus_pkg::byte_t     zb_wdata,
	output logic                  zb_rnw,
	output logic                  z80_busreq_n,
	output logic                  z80_reset_n
);

	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_SELECT   = 3'd1;
	localparam logic [2:0] ST_ROM_WAIT = 3'd2;
	localparam logic [2:0] ST_RAM_READ = 3'd3;
	localparam logic [2:0] ST_ZB_WAIT  = 3'd4;
	localparam logic [2:0] ST_FINISH   = 3'd5;

	logic [2:0]            state;

	// Latched access
	md_bus_pkg::cpu_addr_t addr_q;
	md_bus_pkg::word_t     wdata_q;
	logic                  rnw_q;
	logic                  uds_q;
	logic                  lds_q;

	md_bus_pkg::word_t     open_bus;
	md_bus_pkg::word_t     ctrl_rdata;

	logic                  in_rom;
	logic                  in_zbus;
	logic                  in_wram;
	logic                  is_busreq;
	logic                  is_reset;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------

	// Everything below the sound window is cartridge space
	assign in_rom    = addr_q[23:20] < md_bus_pkg::ZBUS_TOP[7:4];
	assign in_zbus   = addr_q[23:16] == md_bus_pkg::ZBUS_TOP;
	assign in_wram   = addr_q[23:21] == md_bus_pkg::WRAM_TOP;
	assign is_busreq = {addr_q, 1'b0} == md_bus_pkg::CTRL_BUSREQ_ADDR;
	assign is_reset  = {addr_q, 1'b0} == md_bus_pkg::CTRL_RESET_ADDR;

	// Only bit 8 is real and the rest is open bus
	always_comb begin
		ctrl_rdata = open_bus;
		ctrl_rdata[8] = is_busreq ? z80_busreq_n : z80_reset_n;
	end

	assign rom_addr   = addr_q;
	assign wram_addr  = addr_q[15:1];
	assign wram_wdata = wdata_q;

	// Byte writes go out for one cycle while the decode is made
	assign wram_we_hi = (state == ST_SELECT) && in_wram && !rnw_q && !uds_q;
	assign wram_we_lo = (state == ST_SELECT) && in_wram && !rnw_q && !lds_q;

	// Even byte when the upper strobe is active
	assign zb_addr  = {addr_q[14:1], uds_q};
	assign zb_wdata = !uds_q ? wdata_q[15:8] : wdata_q[7:0];
	assign zb_rnw   = rnw_q;

	// ----------------------------------------
	// Access state machine
	// ----------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state        <= ST_IDLE;
			cpu_dtack_n  <= 1'b1;
			rom_req      <= 1'b0;
			zb_sel       <= 1'b0;
			open_bus     <= md_bus_pkg::OPEN_BUS_INIT;
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else begin
			if (cpu_as_n)
				cpu_dtack_n <= 1'b1;

			case (state)
			ST_IDLE: begin
				if (!cpu_as_n && cpu_dtack_n) begin
					addr_q    <= cpu_addr;
					wdata_q   <= cpu_wdata;
					rnw_q     <= cpu_rnw;
					uds_q     <= cpu_uds_n;
					lds_q     <= cpu_lds_n;
					// Unmapped space returns this unchanged
					cpu_rdata <= open_bus;
					state     <= ST_SELECT;
				end
			end

			ST_SELECT: begin
				state <= ST_FINISH;
				if (in_rom) begin
					if (rnw_q && addr_q < rom_size) begin
						rom_req <= ~rom_req;
						state   <= ST_ROM_WAIT;
					end else begin
						// ROM is not touched past the end of the image
						cpu_rdata <= '0;
					end
				end else if (in_zbus) begin
					zb_sel <= 1'b1;
					state  <= ST_ZB_WAIT;
				end else if (is_busreq || is_reset) begin
					if (!rnw_q && !uds_q) begin
						if (is_busreq)
							z80_busreq_n <= ~wdata_q[8];
						else
							z80_reset_n <= wdata_q[8];
					end
					cpu_rdata <= ctrl_rdata;
				end else if (in_wram && rnw_q) begin
					state <= ST_RAM_READ;
				end
			end

			ST_ROM_WAIT: begin
				if (rom_req == rom_ack) begin
					cpu_rdata <= rom_rdata;
					open_bus  <= rom_rdata;
					state     <= ST_FINISH;
				end
			end

			ST_RAM_READ: begin
				cpu_rdata <= wram_rdata;
				open_bus  <= wram_rdata;
				state     <= ST_FINISH;
			end

			ST_ZB_WAIT: begin
				if (zb_done) begin
					zb_sel    <= 1'b0;
					cpu_rdata <= {zb_rdata, zb_rdata};
					state     <= ST_FINISH;
				end
			end

			ST_FINISH: begin
				cpu_dtack_n <= 1'b0;
				state       <= ST_IDLE;
			end

			default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// Protocol checks
	// ----------------------------------------

	// DTACK must drop back once the master has let go of AS
	a_dtack_release: assert property (@(posedge MCLK) disable iff (reset)
		(cpu_as_n && !cpu_dtack_n) |=> cpu_dtack_n);

	// No second toggle before the responder caught up
	a_rom_req_hold: assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != rom_ack) |=> $stable(rom_req));

endmodule

// ==== md_bus_top.sv ====
// Main-bus side only; one 68000 access in flight at a time, sound CPU and FM chip are external or absent
`timescale 1ns/10ps

module md_bus_top #(
	parameter int WRAM_AW = 15,
	parameter int ZRAM_AW = 13
) (
	input  logic                  MCLK,
	input  logic                  reset,

	// 68000 master
	input  logic                  cpu_as_n,
	input  logic                  cpu_rnw,
	input  logic                  cpu_uds_n,
	input  logic                  cpu_lds_n,
	input  md_bus_pkg::cpu_addr_t cpu_addr,
	input  md_bus_pkg::word_t     cpu_wdata,
	output md_bus_pkg::word_t     cpu_rdata,
	output logic                  cpu_dtack_n,

	// Cartridge ROM, toggle handshake
	output md_bus_pkg::cpu_addr_t rom_addr,
	output logic                  rom_req,
	input  md_bus_pkg::word_t     rom_rdata,
	input  logic                  rom_ack,
	input  md_bus_pkg::cpu_addr_t rom_size,

	// Sound CPU control
	output logic                  z80_busreq_n,
	output logic                  z80_reset_n
);

	logic [14:0]           wram_addr;
	md_bus_pkg::word_t     wram_wdata;
	md_bus_pkg::word_t     wram_rdata;
	logic                  wram_we_hi;
	logic                  wram_we_lo;

	logic                  zb_sel;
	logic [14:0]           zb_addr;
	md_bus_pkg::byte_t     zb_wdata;
	logic                  zb_rnw;
	md_bus_pkg::byte_t     zb_rdata;
	logic                  zb_done;

	mbus_ctrl u_mbus_ctrl (
		.MCLK         (MCLK),
		.reset        (reset),
		.cpu_as_n     (cpu_as_n),
		.cpu_rnw      (cpu_rnw),
		.cpu_uds_n    (cpu_uds_n),
		.cpu_lds_n    (cpu_lds_n),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.rom_rdata    (rom_rdata),
		.rom_ack      (rom_ack),
		.rom_size     (rom_size),
		.wram_rdata   (wram_rdata),
		.zb_rdata     (zb_rdata),
		.zb_done      (zb_done),
		.cpu_rdata    (cpu_rdata),
		.cpu_dtack_n  (cpu_dtack_n),
		.rom_addr     (rom_addr),
		.rom_req      (rom_req),
		.wram_addr    (wram_addr),
		.wram_wdata   (wram_wdata),
		.wram_we_hi   (wram_we_hi),
		.wram_we_lo   (wram_we_lo),
		.zb_sel       (zb_sel),
		.zb_addr      (zb_addr),
		.zb_wdata     (zb_wdata),
		.zb_rnw       (zb_rnw),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n)
	);

	work_ram #(.WRAM_AW(WRAM_AW)) u_work_ram (
		.MCLK       (MCLK),
		.wram_addr  (wram_addr),
		.wram_wdata (wram_wdata),
		.wram_we_hi (wram_we_hi),
		.wram_we_lo (wram_we_lo),
		.wram_rdata (wram_rdata)
	);

	// Grant is derived from the same two control outputs the sound CPU sees
	zbus_ctrl #(.ZRAM_AW(ZRAM_AW)) u_zbus_ctrl (
		.MCLK        (MCLK),
		.reset       (reset),
		.zb_sel      (zb_sel),
		.zb_addr     (zb_addr),
		.zb_wdata    (zb_wdata),
		.zb_rnw      (zb_rnw),
		.zb_busreq_n (z80_busreq_n),
		.zb_reset_n  (z80_reset_n),
		.zb_rdata    (zb_rdata),
		.zb_done     (zb_done)
	);

endmodule

// ==== tb_md_bus.sv ====
// Drives one 68000 access at a time; work RAM and sound RAM are read back only where first written
`timescale 1ns/10ps

module tb_md_bus;

	localparam int N_ACCESS    = 220;
	localparam int RESET_CYC   = 16;
	localparam int CYCLE_LIMIT = N_ACCESS * 200 + RESET_CYC;
	localparam logic [22:0] ROM_WORDS = 23'h010000;

	logic MCLK;
	logic reset;
	logic cpu_as_n;
	logic cpu_rnw;
	logic cpu_uds_n;
	logic cpu_lds_n;
	md_bus_pkg::cpu_addr_t cpu_addr;
	md_bus_pkg::word_t     cpu_wdata;
	md_bus_pkg::word_t     cpu_rdata;
	logic cpu_dtack_n;
	md_bus_pkg::cpu_addr_t rom_addr;
	logic rom_req;
	md_bus_pkg::word_t     rom_rdata;
	logic rom_ack;
	md_bus_pkg::cpu_addr_t rom_size;
	logic z80_busreq_n;
	logic z80_reset_n;

	integer seed = 30;
	int cycles = 0;
	int checks = 0;
	int errors = 0;

	// Shadow state of the bus
	logic [15:0] wram_m [0:32767];
	logic [7:0]  zram_m [0:8191];
	logic [15:0] open_bus_m;
	logic        busreq_m;
	logic        rst_n_m;

	logic [15:0] got_q [$];
	logic [15:0] exp_q [$];
	logic [23:0] where_q [$];

	md_bus_top u_dut (
		.MCLK (MCLK), .reset (reset),
		.cpu_as_n (cpu_as_n), .cpu_rnw (cpu_rnw),
		.cpu_uds_n (cpu_uds_n), .cpu_lds_n (cpu_lds_n),
		.cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata), .cpu_dtack_n (cpu_dtack_n),
		.rom_addr (rom_addr), .rom_req (rom_req), .rom_rdata (rom_rdata),
		.rom_ack (rom_ack), .rom_size (rom_size),
		.z80_busreq_n (z80_busreq_n), .z80_reset_n (z80_reset_n)
	);

	initial begin
		MCLK = 1'b0;
		forever #20 MCLK = ~MCLK;
	end

	// ----------------------------------------
	// Reference model
	// ----------------------------------------

	function automatic logic [15:0] rom_word(input logic [23:1] wa);
		return wa[16:1] ^ 16'hA5A5;
	endfunction

	function automatic logic [15:0] ref_read(input logic [23:0] a, input logic uds_n);
		logic [14:0] za;
		logic [15:0] w;
		za = {a[14:1], uds_n};
		w = open_bus_m;
		if (a[23:20] < 4'hA)
			w = (a[23:1] < ROM_WORDS) ? rom_word(a[23:1]) : 16'h0000;
		else if (a[23:16] == md_bus_pkg::ZBUS_TOP)
			w = (!(busreq_m && rst_n_m) || za[14]) ? 16'hFFFF : {2{zram_m[za[12:0]]}};
		else if (a == md_bus_pkg::CTRL_BUSREQ_ADDR)
			w[8] = ~busreq_m;
		else if (a == md_bus_pkg::CTRL_RESET_ADDR)
			w[8] = rst_n_m;
		else if (a[23:21] == md_bus_pkg::WRAM_TOP)
			w = wram_m[a[15:1]];
		return w;
	endfunction

	task automatic model_write(input logic [23:0] a, input logic uds_n, input logic lds_n,
			input logic [15:0] wd);
		logic [14:0] za;
		za = {a[14:1], uds_n};
		if (a[23:21] == md_bus_pkg::WRAM_TOP) begin
			if (!uds_n)
				wram_m[a[15:1]][15:8] = wd[15:8];
			if (!lds_n)
				wram_m[a[15:1]][7:0] = wd[7:0];
		end else if (a[23:16] == md_bus_pkg::ZBUS_TOP) begin
			if (busreq_m && rst_n_m && !za[14])
				zram_m[za[12:0]] = uds_n ? wd[7:0] : wd[15:8];
		end else if (a == md_bus_pkg::CTRL_BUSREQ_ADDR && !uds_n) begin
			busreq_m = wd[8];
		end else if (a == md_bus_pkg::CTRL_RESET_ADDR && !uds_n) begin
			rst_n_m = wd[8];
		end
	endtask

	task automatic check_equal(input logic [15:0] got, input logic [15:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	// ----------------------------------------
	// Master and ROM responder
	// ----------------------------------------

	task automatic bus_access(input logic [23:0] a, input logic rnw, input logic uds_n,
			input logic lds_n, input logic [15:0] wd, output logic [15:0] rd);
		@(negedge MCLK);
		cpu_addr  = a[23:1];
		cpu_rnw   = rnw;
		cpu_uds_n = uds_n;
		cpu_lds_n = lds_n;
		cpu_wdata = wd;
		cpu_as_n  = 1'b0;
		do @(negedge MCLK); while (cpu_dtack_n);
		rd = cpu_rdata;
		cpu_as_n = 1'b1;
		do @(negedge MCLK); while (!cpu_dtack_n);
	endtask

	task automatic do_read(input logic [23:0] a, input logic uds_n, input logic lds_n);
		logic [15:0] exp;
		logic [15:0] rd;
		exp = ref_read(a, uds_n);
		bus_access(a, 1'b1, uds_n, lds_n, 16'h0000, rd);
		got_q.push_back(rd);
		exp_q.push_back(exp);
		where_q.push_back(a);
		// Only real ROM and work-RAM data lands on the open bus
		if ((a[23:20] < 4'hA && a[23:1] < ROM_WORDS) || a[23:21] == md_bus_pkg::WRAM_TOP)
			open_bus_m = exp;
	endtask

	task automatic do_write(input logic [23:0] a, input logic uds_n, input logic lds_n,
			input logic [15:0] wd);
		logic [15:0] rd;
		bus_access(a, 1'b0, uds_n, lds_n, wd, rd);
		model_write(a, uds_n, lds_n, wd);
		if (a == md_bus_pkg::CTRL_BUSREQ_ADDR || a == md_bus_pkg::CTRL_RESET_ADDR)
			check_equal({14'b0, z80_busreq_n, z80_reset_n}, {14'b0, ~busreq_m, rst_n_m},
				"sound CPU control outputs");
	endtask

	initial begin : rom_responder
		int delay;
		rom_ack   = 1'b0;
		rom_rdata = '0;
		forever begin
			@(negedge MCLK);
			if (!reset && rom_req !== rom_ack) begin
				delay = $unsigned($random(seed)) % 6;
				repeat (delay) @(negedge MCLK);
				rom_rdata = rom_word(rom_addr);
				rom_ack   = rom_req;
			end
		end
	end

	always @(negedge MCLK) begin : compare_reads
		logic [15:0] g;
		logic [15:0] e;
		logic [23:0] w;
		while (got_q.size() > 0) begin
			g = got_q.pop_front();
			e = exp_q.pop_front();
			w = where_q.pop_front();
			check_equal(g, e, $sformatf("read at %h", w));
		end
	end

	always @(posedge MCLK) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the bus stopped answering", cycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	initial begin
		logic [31:0] r;
		logic [23:0] wlist [16];
		logic [23:0] zlist [16];
		logic        zuds [16];
		int i;
		reset = 1'b1;
		cpu_as_n = 1'b1;
		cpu_rnw = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		rom_size = ROM_WORDS;
		open_bus_m = 16'h4E71;
		busreq_m = 1'b0;
		rst_n_m = 1'b0;
		repeat (RESET_CYC) @(negedge MCLK);
		reset = 1'b0;

		do_read(24'hA10000, 1'b0, 1'b0);

		// Full-word work-RAM writes first so every listed word is known
		for (i = 0; i < 16; i++) begin
			r = $random(seed);
			wlist[i] = {3'b111, r[20:1], 1'b0};
			do_write(wlist[i], 1'b0, 1'b0, r[31:16]);
		end
		for (i = 0; i < 40; i++) begin
			r = $random(seed);
			do_write(wlist[r[3:0]], r[4] & ~r[5], r[5] & ~r[4], r[31:16]);
		end
		for (i = 0; i < 16; i++)
			do_read(wlist[i], 1'b0, 1'b0);
		do_read(24'hA12000, 1'b0, 1'b0);

		// ROM inside and past the image
		for (i = 0; i < 20; i++) begin
			r = $random(seed);
			do_read({7'b0, r[16:1], 1'b0}, 1'b0, 1'b0);
		end
		do_read(24'h020000, 1'b0, 1'b0);
		do_read(24'h0200FE, 1'b0, 1'b0);
		do_read(24'h100000, 1'b0, 1'b0);
		do_read(24'h800000, 1'b0, 1'b0);
		do_read(24'h9FFFFE, 1'b0, 1'b0);
		do_read(24'hC00000, 1'b0, 1'b0);

		// Sound window while not granted
		do_read(md_bus_pkg::CTRL_BUSREQ_ADDR, 1'b0, 1'b0);
		do_read(md_bus_pkg::CTRL_RESET_ADDR, 1'b0, 1'b0);
		for (i = 0; i < 8; i++) begin
			r = $random(seed);
			do_write({8'hA0, 2'b00, r[13:1], 1'b0}, 1'b0, 1'b1, r[31:16]);
			do_read({8'hA0, 2'b00, r[13:1], 1'b0}, 1'b0, 1'b0);
		end

		// Request alone is no grant and lower-byte writes do nothing
		do_write(md_bus_pkg::CTRL_BUSREQ_ADDR, 1'b0, 1'b0, 16'h0100);
		do_read(24'hA00010, 1'b0, 1'b0);
		do_write(md_bus_pkg::CTRL_RESET_ADDR, 1'b1, 1'b0, 16'hFFFF);
		do_write(md_bus_pkg::CTRL_RESET_ADDR, 1'b0, 1'b0, 16'h0100);
		do_read(md_bus_pkg::CTRL_BUSREQ_ADDR, 1'b0, 1'b0);
		do_read(md_bus_pkg::CTRL_RESET_ADDR, 1'b0, 1'b0);

		// Granted sound RAM and the empty FM range
		for (i = 0; i < 16; i++) begin
			r = $random(seed);
			zlist[i] = {8'hA0, 2'b00, r[13:1], 1'b0};
			zuds[i] = r[0];
			do_write(zlist[i], zuds[i], ~zuds[i], r[31:16]);
		end
		for (i = 0; i < 16; i++)
			do_read(zlist[i], zuds[i], ~zuds[i]);
		// FM write aimed at the RAM mirror of the first entry, inverted data
		do_write(zlist[0] | 24'h004000, zuds[0], ~zuds[0],
			~{2{zram_m[{zlist[0][12:1], zuds[0]}]}});
		for (i = 0; i < 4; i++) begin
			r = $random(seed);
			do_read({8'hA0, 2'b01, r[13:1], 1'b0}, 1'b0, 1'b0);
		end

		// Writes must not land once the request is dropped
		do_write(md_bus_pkg::CTRL_BUSREQ_ADDR, 1'b0, 1'b0, 16'h0000);
		for (i = 0; i < 8; i++) begin
			do_write(zlist[i], zuds[i], ~zuds[i], 16'h5A5A);
			do_read(zlist[i], zuds[i], ~zuds[i]);
		end
		do_write(md_bus_pkg::CTRL_BUSREQ_ADDR, 1'b0, 1'b0, 16'h0100);
		for (i = 0; i < 16; i++)
			do_read(zlist[i], zuds[i], ~zuds[i]);

		do_write(md_bus_pkg::CTRL_RESET_ADDR, 1'b0, 1'b0, 16'h0000);
		do_read(md_bus_pkg::CTRL_RESET_ADDR, 1'b0, 1'b0);
		do_read(24'hB00000, 1'b0, 1'b0);

		repeat (4) @(negedge MCLK);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== tb.f ====
md_bus_pkg.sv
work_ram.sv
zbus_ctrl.sv
mbus_ctrl.sv
md_bus_top.sv
tb_md_bus.sv

// ==== Bender.yml ====
package:
  name: md_bus

sources:
  - files:
      - md_bus_pkg.sv
      - work_ram.sv
      - zbus_ctrl.sv
      - mbus_ctrl.sv
      - md_bus_top.sv
  - target: simulation
    files:
      - tb_md_bus.sv
